// File: brew_sequencer.sv
`timescale 1ns/10ps

module brew_sequencer #(
    parameter int PAPER_CYCLES = 4,
    parameter int POUR_CYCLES  = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                abort,
    input  logic                fault_sw,
    input  logic                can_brew,
    input  recipe_pkg::drink_t  drink_sel,
    input  recipe_pkg::size_t   size_sel,
    output logic                paper_motor_on,
    output logic                grinder_on,
    output logic                pour_on,
    output logic                brewing,
    output logic                brew_done,
    output logic                consume,
    output recipe_pkg::drink_t  order_drink,
    output recipe_pkg::size_t   order_size,
    output panel_pkg::pct_t     brew_progress
);

    import recipe_pkg::*;

    // ========================================
    // Stage counter sizing
    // ========================================

    // Longest of paper, pour and the largest grind
    localparam int MAX_FIXED = (PAPER_CYCLES > POUR_CYCLES) ? PAPER_CYCLES : POUR_CYCLES;
    localparam int LONGEST   = (MAX_FIXED > int'(DOSE_LARGE)) ? MAX_FIXED : int'(DOSE_LARGE);
    localparam int CNT_W     = $clog2(LONGEST + 1);

    // Counter counts down to zero, so load length minus one
    localparam logic [CNT_W-1:0] PAPER_LOAD = CNT_W'(PAPER_CYCLES - 1);
    localparam logic [CNT_W-1:0] POUR_LOAD  = CNT_W'(POUR_CYCLES - 1);

    typedef enum logic [2:0] {
        IDLE,
        PAPER,
        GRIND,
        POUR,
        DONE
    } state_t;

    state_t           state;
    state_t           state_nxt;
    logic [CNT_W-1:0] stage_cnt;
    logic [CNT_W-1:0] cnt_nxt;
    logic [CNT_W-1:0] grind_load;
    logic             accept;
    logic             done_q;

    // Grind length follows the latched size
    assign grind_load = CNT_W'(coffee_dose(order_size) - level_t'(1));

    // Order taken only from rest, with stock and no fault
    assign accept = start && can_brew && !fault_sw && !abort
                    && (state == IDLE || state == DONE);

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_nxt = state;
        cnt_nxt   = stage_cnt;
        if (brewing && (abort || fault_sw)) begin
            // Emergency stop, drop the order
            state_nxt = IDLE;
            cnt_nxt   = '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state_nxt = PAPER;
                        cnt_nxt   = PAPER_LOAD;
                    end else if (abort) begin
                        // Clears the 100 percent readout
                        state_nxt = IDLE;
                    end
                end
                PAPER: begin
                    if (stage_cnt == '0) begin
                        state_nxt = GRIND;
                        cnt_nxt   = grind_load;
                    end else begin
                        cnt_nxt = stage_cnt - 1'b1;
                    end
                end
                GRIND: begin
                    if (stage_cnt == '0) begin
                        state_nxt = POUR;
                        cnt_nxt   = POUR_LOAD;
                    end else begin
                        cnt_nxt = stage_cnt - 1'b1;
                    end
                end
                POUR: begin
                    if (stage_cnt == '0) begin
                        state_nxt = DONE;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = stage_cnt - 1'b1;
                    end
                end
                default: begin
                    state_nxt = IDLE;
                    cnt_nxt   = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            stage_cnt <= '0;
            done_q    <= 1'b0;
        end else begin
            state     <= state_nxt;
            stage_cnt <= cnt_nxt;
            // Single pulse on the way into DONE
            done_q    <= (state == POUR) && (state_nxt == DONE);
        end
    end

    // Order held for the whole brew
    always_ff @(posedge clk) begin
        if (accept) begin
            order_drink <= drink_sel;
            order_size  <= size_sel;
        end
    end

    // ========================================
    // Output decode
    // ========================================
    always_comb begin
        paper_motor_on = (state == PAPER);
        grinder_on     = (state == GRIND);
        pour_on        = (state == POUR);
        brewing        = paper_motor_on || grinder_on || pour_on;
        case (state)
            PAPER:   brew_progress = 7'd25;
            GRIND:   brew_progress = 7'd50;
            POUR:    brew_progress = 7'd75;
            DONE:    brew_progress = 7'd100;
            default: brew_progress = 7'd0;
        endcase
    end

    // Store deducts on the same pulse
    assign brew_done = done_q;
    assign consume   = done_q;

    // Never two actuators at once
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({paper_motor_on, grinder_on, pour_on}));

    // Completion only straight out of the pour stage
    assert property (@(posedge clk) disable iff (!rst_n)
        brew_done |-> ($past(state) == POUR) && !$past(brew_done));

endmodule

// File: coffee_brew_top.sv
`timescale 1ns/10ps

module coffee_brew_top #(
    parameter int FULL_LEVEL      = 64,
    parameter int FILTER_CAPACITY = 8,
    parameter int LOW_THRESHOLD   = 16,
    parameter int PAPER_CYCLES    = 4,
    parameter int POUR_CYCLES     = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    // Single-cycle command pulses
    input  logic                start,
    input  logic                abort,
    input  logic                refill,
    // Selection and fault levels
    input  recipe_pkg::drink_t  drink_sel,
    input  recipe_pkg::size_t   size_sel,
    input  logic                fault_sw,
    // Actuators and brew status
    output logic                paper_motor_on,
    output logic                grinder_on,
    output logic                pour_on,
    output logic                brewing,
    output logic                brew_done,
    output panel_pkg::pct_t     brew_progress,
    // Consumables
    output recipe_pkg::level_t  bin0_level,
    output recipe_pkg::level_t  bin1_level,
    output recipe_pkg::level_t  creamer_level,
    output recipe_pkg::level_t  chocolate_level,
    output recipe_pkg::level_t  filter_count,
    output logic                can_brew,
    // Panel
    output panel_pkg::count_t   warn_count,
    output panel_pkg::count_t   err_count,
    output logic                error_present,
    output panel_pkg::seg_t     hex0,
    output panel_pkg::seg_t     hex1,
    output panel_pkg::seg_t     hex2
);

    import recipe_pkg::*;

    // Latched order and deduction strobe toward the store
    logic   consume;
    drink_t order_drink;
    size_t  order_size;

    // ========================================
    // Sequencer
    // ========================================
    brew_sequencer #(
        .PAPER_CYCLES (PAPER_CYCLES),
        .POUR_CYCLES  (POUR_CYCLES)
    ) u_brew_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .abort          (abort),
        .fault_sw       (fault_sw),
        .can_brew       (can_brew),
        .drink_sel      (drink_sel),
        .size_sel       (size_sel),
        .paper_motor_on (paper_motor_on),
        .grinder_on     (grinder_on),
        .pour_on        (pour_on),
        .brewing        (brewing),
        .brew_done      (brew_done),
        .consume        (consume),
        .order_drink    (order_drink),
        .order_size     (order_size),
        .brew_progress  (brew_progress)
    );

    // Levels and stock check
    ingredient_store #(
        .FULL_LEVEL      (FULL_LEVEL),
        .FILTER_CAPACITY (FILTER_CAPACITY)
    ) u_ingredient_store (
        .clk             (clk),
        .rst_n           (rst_n),
        .refill          (refill),
        .consume         (consume),
        .order_drink     (order_drink),
        .order_size      (order_size),
        .drink_sel       (drink_sel),
        .size_sel        (size_sel),
        .bin0_level      (bin0_level),
        .bin1_level      (bin1_level),
        .creamer_level   (creamer_level),
        .chocolate_level (chocolate_level),
        .filter_count    (filter_count),
        .can_brew        (can_brew)
    );

    // Purely combinational display side
    status_panel #(
        .LOW_THRESHOLD (LOW_THRESHOLD)
    ) u_status_panel (
        .bin0_level      (bin0_level),
        .bin1_level      (bin1_level),
        .creamer_level   (creamer_level),
        .chocolate_level (chocolate_level),
        .filter_count    (filter_count),
        .fault_sw        (fault_sw),
        .brew_progress   (brew_progress),
        .warn_count      (warn_count),
        .err_count       (err_count),
        .error_present   (error_present),
        .hex0            (hex0),
        .hex1            (hex1),
        .hex2            (hex2)
    );

endmodule

// File: ingredient_store.sv
`timescale 1ns/10ps

module ingredient_store #(
    parameter int FULL_LEVEL      = 64,
    parameter int FILTER_CAPACITY = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                refill,
    input  logic                consume,
    input  recipe_pkg::drink_t  order_drink,
    input  recipe_pkg::size_t   order_size,
    input  recipe_pkg::drink_t  drink_sel,
    input  recipe_pkg::size_t   size_sel,
    output recipe_pkg::level_t  bin0_level,
    output recipe_pkg::level_t  bin1_level,
    output recipe_pkg::level_t  creamer_level,
    output recipe_pkg::level_t  chocolate_level,
    output recipe_pkg::level_t  filter_count,
    output logic                can_brew
);

    import recipe_pkg::*;

    localparam level_t FULL    = level_t'(FULL_LEVEL);
    localparam level_t FILTERS = level_t'(FILTER_CAPACITY);

    // Per-hopper deduction for the latched order
    level_t order_dose;
    level_t bin0_use;
    level_t bin1_use;
    level_t creamer_use;
    level_t chocolate_use;
    logic   order_ok;

    // ========================================
    // Stock check
    // ========================================

    // True when every hopper the recipe touches holds its dose
    function automatic logic stock_ok(input drink_t drink, input size_t size);
        level_t dose;
        logic   ok;
        dose = coffee_dose(size);
        // One paper filter per brew
        ok = (filter_count != '0);
        if (drink == DRINK_BOLD) begin
            ok = ok && (bin1_level >= dose);
        end else begin
            ok = ok && (bin0_level >= dose);
        end
        if (drink == DRINK_CREAM) begin
            ok = ok && (creamer_level >= CREAMER_DOSE);
        end
        if (drink == DRINK_MOCHA) begin
            ok = ok && (chocolate_level >= CHOCOLATE_DOSE);
        end
        return ok;
    endfunction

    // Selection check feeds the sequencer, order check the assertion
    always_comb begin
        can_brew = stock_ok(drink_sel, size_sel);
        order_ok = stock_ok(order_drink, order_size);
    end

    // ========================================
    // Recipe deduction
    // ========================================
    always_comb begin
        order_dose    = coffee_dose(order_size);
        bin0_use      = (order_drink == DRINK_BOLD) ? '0 : order_dose;
        bin1_use      = (order_drink == DRINK_BOLD) ? order_dose : '0;
        creamer_use   = (order_drink == DRINK_CREAM) ? CREAMER_DOSE : '0;
        chocolate_use = (order_drink == DRINK_MOCHA) ? CHOCOLATE_DOSE : '0;
    end

    // Hoppers come up full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bin0_level      <= FULL;
            bin1_level      <= FULL;
            creamer_level   <= FULL;
            chocolate_level <= FULL;
            filter_count    <= FILTERS;
        end else if (refill) begin
            // Refill wins over a same-cycle deduction
            bin0_level      <= FULL;
            bin1_level      <= FULL;
            creamer_level   <= FULL;
            chocolate_level <= FULL;
            filter_count    <= FILTERS;
        end else if (consume) begin
            bin0_level      <= bin0_level - bin0_use;
            bin1_level      <= bin1_level - bin1_use;
            creamer_level   <= creamer_level - creamer_use;
            chocolate_level <= chocolate_level - chocolate_use;
            filter_count    <= filter_count - level_t'(1);
        end
    end

    // Sequencer must only finish orders that stock can cover
    assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> order_ok);

endmodule

// File: panel_pkg.sv
package panel_pkg;

    // Progress in percent, 0 to 100
    typedef logic [6:0] pct_t;

    // One decimal digit
    typedef logic [3:0] digit_t;

    // Active-low segments, a in bit 0, g in bit 6
    typedef logic [6:0] seg_t;

    // Warning or error tally
    typedef logic [2:0] count_t;

    // ========================================
    // Digit patterns 0 to 9
    // ========================================
    localparam seg_t SEG_DIGITS [0:9] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

endpackage

// File: recipe_pkg.sv
package recipe_pkg;

    // ========================================
    // Quantities
    // ========================================

    // Hopper contents or filter stack size
    typedef logic [7:0] level_t;

    // ========================================
    // Order encodings
    // ========================================

    // Bin0 feeds every drink except bold
    typedef enum logic [1:0] {
        DRINK_HOUSE = 2'd0,
        DRINK_BOLD  = 2'd1,
        DRINK_CREAM = 2'd2,
        DRINK_MOCHA = 2'd3
    } drink_t;

    // Code 3 is unused and brews as large
    typedef enum logic [1:0] {
        SIZE_SMALL  = 2'd0,
        SIZE_MEDIUM = 2'd1,
        SIZE_LARGE  = 2'd2
    } size_t;

    // Coffee dose per cup size
    localparam level_t DOSE_SMALL  = 8'd8;
    localparam level_t DOSE_MEDIUM = 8'd12;
    localparam level_t DOSE_LARGE  = 8'd16;

    // Add-in doses, independent of size
    localparam level_t CREAMER_DOSE   = 8'd4;
    localparam level_t CHOCOLATE_DOSE = 8'd6;

    // Size to coffee units, also the grind length in cycles
    function automatic level_t coffee_dose(input size_t size);
        case (size)
            SIZE_SMALL:  return DOSE_SMALL;
            SIZE_MEDIUM: return DOSE_MEDIUM;
            default:     return DOSE_LARGE;
        endcase
    endfunction

endpackage

// File: src.f
recipe_pkg.sv
panel_pkg.sv
brew_sequencer.sv
ingredient_store.sv
status_panel.sv
coffee_brew_top.sv
tb_coffee_brew.sv

// File: status_panel.sv
`timescale 1ns/10ps

module status_panel #(
    parameter int LOW_THRESHOLD = 16
) (
    input  recipe_pkg::level_t  bin0_level,
    input  recipe_pkg::level_t  bin1_level,
    input  recipe_pkg::level_t  creamer_level,
    input  recipe_pkg::level_t  chocolate_level,
    input  recipe_pkg::level_t  filter_count,
    input  logic                fault_sw,
    input  panel_pkg::pct_t     brew_progress,
    output panel_pkg::count_t   warn_count,
    output panel_pkg::count_t   err_count,
    output logic                error_present,
    output panel_pkg::seg_t     hex0,
    output panel_pkg::seg_t     hex1,
    output panel_pkg::seg_t     hex2
);

    import recipe_pkg::*;
    import panel_pkg::*;

    localparam level_t LOW_LEVEL = level_t'(LOW_THRESHOLD);

    // Bits 0 to 3 hoppers, bit 4 filters, bit 5 fault switch
    logic [4:0] warn_flags;
    logic [5:0] err_flags;

    digit_t hundreds;
    digit_t tens;
    digit_t ones;

    // Low means running short but not yet out
    function automatic logic is_low(input level_t level);
        return (level != '0) && (level < LOW_LEVEL);
    endfunction

    // ========================================
    // Warning and error tallies
    // ========================================
    always_comb begin
        warn_flags[0] = is_low(bin0_level);
        warn_flags[1] = is_low(bin1_level);
        warn_flags[2] = is_low(creamer_level);
        warn_flags[3] = is_low(chocolate_level);
        // Last filter in the stack
        warn_flags[4] = (filter_count == level_t'(1));

        err_flags[0] = (bin0_level == '0);
        err_flags[1] = (bin1_level == '0);
        err_flags[2] = (creamer_level == '0);
        err_flags[3] = (chocolate_level == '0);
        err_flags[4] = (filter_count == '0);
        err_flags[5] = fault_sw;
    end

    always_comb begin
        warn_count = '0;
        err_count  = '0;
        for (int i = 0; i < 5; i++) begin
            warn_count = warn_count + count_t'(warn_flags[i]);
        end
        for (int i = 0; i < 6; i++) begin
            err_count = err_count + count_t'(err_flags[i]);
        end
    end

    assign error_present = (err_count != '0);

    // ========================================
    // Progress digits
    // ========================================

    // Hundreds is only ever 0 or 1
    assign hundreds = (brew_progress >= 7'd100) ? digit_t'(1) : digit_t'(0);
    assign tens     = digit_t'((brew_progress % 7'd100) / 7'd10);
    assign ones     = digit_t'(brew_progress % 7'd10);

    // HEX2 leftmost
    assign hex2 = SEG_DIGITS[hundreds];
    assign hex1 = SEG_DIGITS[tens];
    assign hex0 = SEG_DIGITS[ones];

endmodule

// File: tb_coffee_brew.sv
`timescale 1ns/10ps

module tb_coffee_brew;

    import recipe_pkg::*;

    localparam int FULL_LEVEL      = 64;
    localparam int FILTER_CAPACITY = 8;
    localparam int LOW_THRESHOLD   = 16;
    localparam int PAPER_CYCLES    = 4;
    localparam int POUR_CYCLES     = 10;

    // Brew attempts in the run, sizes the watchdog
    localparam int NUM_BREWS       = 31;
    localparam int WATCHDOG_CYCLES =
        NUM_BREWS * (PAPER_CYCLES + 16 + POUR_CYCLES + 4) + 200;

    // Coffee units per size code, code 3 brews as large
    localparam int DOSE_TABLE [0:3] = '{8, 12, 16, 16};
    localparam int CREAM_UNITS      = 4;
    localparam int CHOC_UNITS       = 6;

    // Active-low digits, segment a in bit 0
    localparam logic [6:0] SEG_TABLE [0:9] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001,
        7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000
    };

    typedef enum {M_IDLE, M_PAPER, M_GRIND, M_POUR, M_DONE} mstage_t;

    logic clk;
    logic rst_n;
    logic start;
    logic abort;
    logic refill;
    drink_t drink_sel;
    size_t size_sel;
    logic fault_sw;
    logic paper_motor_on;
    logic grinder_on;
    logic pour_on;
    logic brewing;
    logic brew_done;
    panel_pkg::pct_t brew_progress;
    level_t bin0_level;
    level_t bin1_level;
    level_t creamer_level;
    level_t chocolate_level;
    level_t filter_count;
    logic can_brew;
    panel_pkg::count_t warn_count;
    panel_pkg::count_t err_count;
    logic error_present;
    panel_pkg::seg_t hex0;
    panel_pkg::seg_t hex1;
    panel_pkg::seg_t hex2;

    // Reference model state, hoppers 0 to 3 then filters
    mstage_t m_stage;
    int m_left;
    logic m_done;
    logic [1:0] m_drink;
    logic [1:0] m_size;
    int m_level [0:4];

    logic exp_can;
    int exp_warn;
    int exp_err;
    int exp_pct;
    logic [6:0] exp_hex0;
    logic [6:0] exp_hex1;
    logic [6:0] exp_hex2;
    integer seed = 32'hb6319e06;

    coffee_brew_top #(
        .FULL_LEVEL      (FULL_LEVEL),
        .FILTER_CAPACITY (FILTER_CAPACITY),
        .LOW_THRESHOLD   (LOW_THRESHOLD),
        .PAPER_CYCLES    (PAPER_CYCLES),
        .POUR_CYCLES     (POUR_CYCLES)
    ) u_coffee_brew_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .abort           (abort),
        .refill          (refill),
        .drink_sel       (drink_sel),
        .size_sel        (size_sel),
        .fault_sw        (fault_sw),
        .paper_motor_on  (paper_motor_on),
        .grinder_on      (grinder_on),
        .pour_on         (pour_on),
        .brewing         (brewing),
        .brew_done       (brew_done),
        .brew_progress   (brew_progress),
        .bin0_level      (bin0_level),
        .bin1_level      (bin1_level),
        .creamer_level   (creamer_level),
        .chocolate_level (chocolate_level),
        .filter_count    (filter_count),
        .can_brew        (can_brew),
        .warn_count      (warn_count),
        .err_count       (err_count),
        .error_present   (error_present),
        .hex0            (hex0),
        .hex1            (hex1),
        .hex2            (hex2)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Units a drink takes from one hopper
    function automatic int need(input int hopper, input logic [1:0] drink,
                                input logic [1:0] size);
        int coffee;
        coffee = DOSE_TABLE[size];
        case (hopper)
            0:       return (drink == DRINK_BOLD) ? 0 : coffee;
            1:       return (drink == DRINK_BOLD) ? coffee : 0;
            2:       return (drink == DRINK_CREAM) ? CREAM_UNITS : 0;
            default: return (drink == DRINK_MOCHA) ? CHOC_UNITS : 0;
        endcase
    endfunction

    // ========================================
    // Reference model
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_stage <= M_IDLE;
            m_left  <= 0;
            m_done  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                m_level[i] <= FULL_LEVEL;
            end
            m_level[4] <= FILTER_CAPACITY;
        end else begin
            m_done <= 1'b0;
            if ((m_stage == M_PAPER || m_stage == M_GRIND || m_stage == M_POUR)
                && (abort || fault_sw)) begin
                // Emergency stop
                m_stage <= M_IDLE;
            end else begin
                case (m_stage)
                    M_IDLE, M_DONE: begin
                        if (start && !abort && !fault_sw && exp_can) begin
                            m_stage <= M_PAPER;
                            m_left  <= PAPER_CYCLES;
                            m_drink <= drink_sel;
                            m_size  <= size_sel;
                        end else if (abort) begin
                            m_stage <= M_IDLE;
                        end
                    end
                    M_PAPER: begin
                        if (m_left == 1) begin
                            m_stage <= M_GRIND;
                            m_left  <= DOSE_TABLE[m_size];
                        end else begin
                            m_left <= m_left - 1;
                        end
                    end
                    M_GRIND: begin
                        if (m_left == 1) begin
                            m_stage <= M_POUR;
                            m_left  <= POUR_CYCLES;
                        end else begin
                            m_left <= m_left - 1;
                        end
                    end
                    default: begin
                        if (m_left == 1) begin
                            m_stage <= M_DONE;
                            m_done  <= 1'b1;
                        end else begin
                            m_left <= m_left - 1;
                        end
                    end
                endcase
            end
            if (refill) begin
                for (int i = 0; i < 4; i++) begin
                    m_level[i] <= FULL_LEVEL;
                end
                m_level[4] <= FILTER_CAPACITY;
            end else if (m_done) begin
                // Recipe leaves the hoppers as the done pulse ends
                for (int i = 0; i < 4; i++) begin
                    m_level[i] <= m_level[i] - need(i, m_drink, m_size);
                end
                m_level[4] <= m_level[4] - 1;
            end
        end
    end

    // Expected stock check, panel tallies and digits
    always_comb begin
        exp_can  = (m_level[4] != 0);
        exp_warn = (m_level[4] == 1) ? 1 : 0;
        exp_err  = (m_level[4] == 0) ? 1 : 0;
        for (int i = 0; i < 4; i++) begin
            if (m_level[i] < need(i, drink_sel, size_sel)) begin
                exp_can = 1'b0;
            end
            if (m_level[i] == 0) begin
                exp_err = exp_err + 1;
            end else if (m_level[i] < LOW_THRESHOLD) begin
                exp_warn = exp_warn + 1;
            end
        end
        if (fault_sw) begin
            exp_err = exp_err + 1;
        end
        case (m_stage)
            M_PAPER: exp_pct = 25;
            M_GRIND: exp_pct = 50;
            M_POUR:  exp_pct = 75;
            M_DONE:  exp_pct = 100;
            default: exp_pct = 0;
        endcase
        exp_hex2 = SEG_TABLE[exp_pct / 100];
        exp_hex1 = SEG_TABLE[(exp_pct / 10) % 10];
        exp_hex0 = SEG_TABLE[exp_pct % 10];
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Error: %s expected 0x%0h actual 0x%0h at %0t",
                 name, expected, actual, $time);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // ========================================
    // Checks
    // ========================================
    assert property (@(posedge clk) disable iff (!rst_n)
        paper_motor_on == (m_stage == M_PAPER))
        else report_mismatch("paper_motor_on", $sampled(m_stage == M_PAPER),
                             $sampled(paper_motor_on));
    assert property (@(posedge clk) disable iff (!rst_n)
        grinder_on == (m_stage == M_GRIND))
        else report_mismatch("grinder_on", $sampled(m_stage == M_GRIND),
                             $sampled(grinder_on));
    assert property (@(posedge clk) disable iff (!rst_n)
        pour_on == (m_stage == M_POUR))
        else report_mismatch("pour_on", $sampled(m_stage == M_POUR),
                             $sampled(pour_on));
    assert property (@(posedge clk) disable iff (!rst_n)
        brewing == (exp_pct inside {25, 50, 75}))
        else report_mismatch("brewing", $sampled(exp_pct inside {25, 50, 75}),
                             $sampled(brewing));
    assert property (@(posedge clk) disable iff (!rst_n) brew_done == m_done)
        else report_mismatch("brew_done", $sampled(m_done), $sampled(brew_done));
    assert property (@(posedge clk) disable iff (!rst_n) brew_progress == exp_pct)
        else report_mismatch("brew_progress", $sampled(exp_pct), $sampled(brew_progress));
    assert property (@(posedge clk) disable iff (!rst_n) bin0_level == m_level[0])
        else report_mismatch("bin0_level", $sampled(m_level[0]), $sampled(bin0_level));
    assert property (@(posedge clk) disable iff (!rst_n) bin1_level == m_level[1])
        else report_mismatch("bin1_level", $sampled(m_level[1]), $sampled(bin1_level));
    assert property (@(posedge clk) disable iff (!rst_n) creamer_level == m_level[2])
        else report_mismatch("creamer_level", $sampled(m_level[2]),
                             $sampled(creamer_level));
    assert property (@(posedge clk) disable iff (!rst_n) chocolate_level == m_level[3])
        else report_mismatch("chocolate_level", $sampled(m_level[3]),
                             $sampled(chocolate_level));
    assert property (@(posedge clk) disable iff (!rst_n) filter_count == m_level[4])
        else report_mismatch("filter_count", $sampled(m_level[4]), $sampled(filter_count));
    assert property (@(posedge clk) disable iff (!rst_n) can_brew == exp_can)
        else report_mismatch("can_brew", $sampled(exp_can), $sampled(can_brew));
    assert property (@(posedge clk) disable iff (!rst_n) warn_count == exp_warn)
        else report_mismatch("warn_count", $sampled(exp_warn), $sampled(warn_count));
    assert property (@(posedge clk) disable iff (!rst_n) err_count == exp_err)
        else report_mismatch("err_count", $sampled(exp_err), $sampled(err_count));
    assert property (@(posedge clk) disable iff (!rst_n) error_present == (exp_err != 0))
        else report_mismatch("error_present", $sampled(exp_err != 0),
                             $sampled(error_present));
    assert property (@(posedge clk) disable iff (!rst_n) hex2 == exp_hex2)
        else report_mismatch("hex2", $sampled(exp_hex2), $sampled(hex2));
    assert property (@(posedge clk) disable iff (!rst_n) hex1 == exp_hex1)
        else report_mismatch("hex1", $sampled(exp_hex1), $sampled(hex1));
    assert property (@(posedge clk) disable iff (!rst_n) hex0 == exp_hex0)
        else report_mismatch("hex0", $sampled(exp_hex0), $sampled(hex0));
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({paper_motor_on, grinder_on, pour_on}))
        else report_failure("More than one actuator was on at once");
    assert property (@(posedge clk) disable iff (!rst_n) brew_done |=> !brew_done)
        else report_failure("brew_done stayed high for more than one cycle");

    // ========================================
    // Stimulus, all on the falling edge
    // ========================================
    task automatic start_only(input drink_t drink, input size_t size);
        drink_sel = drink;
        size_sel  = size;
        start     = 1'b1;
        @(negedge clk);
        start     = 1'b0;
    endtask

    // Rejected orders return at once, accepted ones after the deduction
    task automatic brew_order(input drink_t drink, input size_t size);
        start_only(drink, size);
        if (brewing) begin
            while (!brew_done) @(negedge clk);
            @(negedge clk);
        end
    endtask

    task automatic pulse_refill();
        refill = 1'b1;
        @(negedge clk);
        refill = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        start     = 1'b0;
        abort     = 1'b0;
        refill    = 1'b0;
        drink_sel = DRINK_HOUSE;
        size_sel  = SIZE_SMALL;
        fault_sw  = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Random orders from a full machine
        for (int n = 0; n < 12; n++) begin
            r = $random(seed);
            brew_order(drink_t'(r[1:0]), size_t'(r[3:2]));
        end
        // Drain bin1 to empty
        pulse_refill();
        repeat (4) brew_order(DRINK_BOLD, SIZE_LARGE);
        // Last four filters, then a start with none left
        repeat (5) brew_order(DRINK_HOUSE, SIZE_SMALL);
        // Bin0 down to a low level, then a start it cannot cover
        pulse_refill();
        repeat (6) brew_order(DRINK_HOUSE, SIZE_MEDIUM);
        // Start blocked by the fault switch
        pulse_refill();
        fault_sw = 1'b1;
        brew_order(DRINK_HOUSE, SIZE_SMALL);
        fault_sw = 1'b0;
        // Abort in the grind stage
        start_only(DRINK_HOUSE, SIZE_SMALL);
        while (!grinder_on) @(negedge clk);
        abort = 1'b1;
        @(negedge clk);
        abort = 1'b0;
        // Fault in the pour stage
        start_only(DRINK_CREAM, SIZE_MEDIUM);
        while (!pour_on) @(negedge clk);
        fault_sw = 1'b1;
        @(negedge clk);
        fault_sw = 1'b0;
        // Abort clears the finished readout
        brew_order(DRINK_MOCHA, SIZE_LARGE);
        abort = 1'b1;
        @(negedge clk);
        abort = 1'b0;
        pulse_refill();
        repeat (3) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the test sequence did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1);
    end

endmodule
